// ==== vga_pkg.sv ====
package vga_pkg;

    // 800x600 at 60 Hz, 40 MHz pixel clock
    localparam logic [10:0] H_TOTAL      = 11'd1056;
    localparam logic [10:0] H_VISIBLE    = 11'd800;
    localparam logic [10:0] H_SYNC_START = 11'd840;
    localparam logic [10:0] H_SYNC_STOP  = 11'd968;

    localparam logic [10:0] V_TOTAL      = 11'd628;
    localparam logic [10:0] V_VISIBLE    = 11'd600;
    localparam logic [10:0] V_SYNC_START = 11'd601;
    localparam logic [10:0] V_SYNC_STOP  = 11'd605;

    // Text rectangle, 16 columns of 8 pixels by 16 rows of 16 lines
    localparam logic [10:0] RECT_X = 11'd300;
    localparam logic [10:0] RECT_Y = 11'd200;
    localparam logic [10:0] RECT_W = 11'd128;
    localparam logic [10:0] RECT_H = 11'd256;

    localparam logic [11:0] BG_COLOR      = 12'h8_8_8;  // Gray
    localparam logic [11:0] TEXT_BG_COLOR = 12'h0_0_4;  // Dark blue

    // One pixel of the video stream
    typedef struct packed {
        logic [10:0] vcount;
        logic        vsync;
        logic        vblnk;
        logic [10:0] hcount;
        logic        hsync;
        logic        hblnk;
        logic [11:0] rgb;   // 4 bits each of R, G, B
    } vga_t;

    // Row in the upper nibble, column in the lower
    typedef logic [7:0] char_addr_t;

endpackage

// ==== vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing (
    input  logic          clk,
    input  logic          rst,
    output vga_pkg::vga_t out
);

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        h_last;
    logic        v_last;

    assign h_last = (hcount == vga_pkg::H_TOTAL - 11'd1);
    assign v_last = (vcount == vga_pkg::V_TOTAL - 11'd1);

    // Frame position
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_last) begin
                hcount <= '0;
                vcount <= v_last ? '0 : vcount + 11'd1;  // Next line at wrap
            end else begin
                hcount <= hcount + 11'd1;
            end
        end
    end

    // Syncs and blanking decoded from the same counter value they travel with
    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.hcount <= hcount;
            out.vcount <= vcount;
            out.hblnk  <= (hcount >= vga_pkg::H_VISIBLE);
            out.vblnk  <= (vcount >= vga_pkg::V_VISIBLE);
            out.hsync  <= (hcount >= vga_pkg::H_SYNC_START) &&
                          (hcount <  vga_pkg::H_SYNC_STOP);
            out.vsync  <= (vcount >= vga_pkg::V_SYNC_START) &&
                          (vcount <  vga_pkg::V_SYNC_STOP);
            out.rgb    <= '0;   // Color is added downstream
        end
    end

    // Line length holds at the output, one clock behind the counter
    hcount_in_range: assert property (
        @(posedge clk) disable iff (rst)
        out.hcount < vga_pkg::H_TOTAL
    ) else $error("hcount reached H_TOTAL");

endmodule

// ==== draw_bg.sv ====
`timescale 1ns/1ns

module draw_bg (
    input  logic          clk,
    input  logic          rst,
    input  vga_pkg::vga_t in,
    output vga_pkg::vga_t out
);

    logic [11:0] rgb_nxt;

    // DAC expects black outside the visible area
    always_comb begin
        if (in.hblnk || in.vblnk) begin
            rgb_nxt = 12'h0_0_0;
        end else begin
            rgb_nxt = vga_pkg::BG_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.vcount <= in.vcount;
            out.vsync  <= in.vsync;
            out.vblnk  <= in.vblnk;
            out.hcount <= in.hcount;
            out.hsync  <= in.hsync;
            out.hblnk  <= in.hblnk;
            out.rgb    <= rgb_nxt;
        end
    end

endmodule

// ==== text_buffer.sv ====
`timescale 1ns/1ns

module text_buffer (
    input  logic                clk,
    input  vga_pkg::char_addr_t char_xy,
    output logic [7:0]          char_code
);

    logic [7:0] rom [256];

    // Fixed message on row 0, spaces elsewhere
    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = 8'h20;
        end
        rom[8'h00] = 8'h48;  // H
        rom[8'h01] = 8'h45;  // E
        rom[8'h02] = 8'h4C;  // L
        rom[8'h03] = 8'h4C;  // L
        rom[8'h04] = 8'h4F;  // O
        rom[8'h05] = 8'h20;
        rom[8'h06] = 8'h56;  // V
        rom[8'h07] = 8'h47;  // G
        rom[8'h08] = 8'h41;  // A
    end

    always_ff @(posedge clk) begin
        char_code <= rom[char_xy];
    end

endmodule

// ==== font_rom.sv ====
`timescale 1ns/1ns

module font_rom (
    input  logic        clk,
    input  logic [11:0] font_addr,    // {char code, line}
    output logic [7:0]  char_pixels
);

    logic [0:15][7:0] glyph;  // Line 0 first, bit 7 is the leftmost pixel
    logic [3:0]       line;

    assign line = font_addr[3:0];

    always_comb begin
        case (font_addr[11:4])
            8'h20: glyph = '0;   // Space
            8'h41: glyph = {8'h00, 8'h00, 8'h18, 8'h24, 8'h42, 8'h42, 8'h42, 8'h42,
                            8'h7E, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h00, 8'h00};
            8'h45: glyph = {8'h00, 8'h00, 8'h7E, 8'h40, 8'h40, 8'h40, 8'h40, 8'h7C,
                            8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h7E, 8'h00, 8'h00};
            8'h47: glyph = {8'h00, 8'h00, 8'h3C, 8'h42, 8'h40, 8'h40, 8'h40, 8'h40,
                            8'h4E, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3C, 8'h00, 8'h00};
            8'h48: glyph = {8'h00, 8'h00, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h7E,
                            8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h00, 8'h00};
            8'h4C: glyph = {8'h00, 8'h00, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40,
                            8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h7E, 8'h00, 8'h00};
            8'h4F: glyph = {8'h00, 8'h00, 8'h3C, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42,
                            8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3C, 8'h00, 8'h00};
            8'h56: glyph = {8'h00, 8'h00, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42,
                            8'h42, 8'h42, 8'h24, 8'h24, 8'h18, 8'h18, 8'h00, 8'h00};
            default: glyph = '0;  // Unused codes stay blank
        endcase
    end

    always_ff @(posedge clk) begin
        char_pixels <= glyph[line];
    end

endmodule

// ==== draw_rect_char.sv ====
`timescale 1ns/1ns

module draw_rect_char (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::vga_t       in,
    output vga_pkg::vga_t       out,
    input  logic [11:0]         fg_color,
    input  logic [7:0]          char_pixels,
    output vga_pkg::char_addr_t char_xy,
    output logic [11:0]         font_addr,
    input  logic [7:0]          char_code
);

    logic [10:0]   hrel;
    logic [10:0]   vrel;
    logic [3:0]    line_d1;
    vga_pkg::vga_t vid_d1;
    vga_pkg::vga_t vid_d2;
    logic [10:0]   hrel_d2;
    logic          in_rect;
    logic          pixel_on;
    logic [11:0]   rgb_nxt;

    // Position relative to the rectangle corner
    assign hrel = in.hcount - vga_pkg::RECT_X;
    assign vrel = in.vcount - vga_pkg::RECT_Y;

    assign char_xy   = {vrel[7:4], hrel[6:3]};
    assign font_addr = {char_code, line_d1};  // Line waits for the text buffer

    // Two delays to line the video up with the font output
    always_ff @(posedge clk) begin
        if (rst) begin
            vid_d1  <= '0;
            vid_d2  <= '0;
            line_d1 <= '0;
        end else begin
            vid_d1  <= in;
            vid_d2  <= vid_d1;
            line_d1 <= vrel[3:0];
        end
    end

    assign hrel_d2 = vid_d2.hcount - vga_pkg::RECT_X;

    assign in_rect = (vid_d2.hcount >= vga_pkg::RECT_X) &&
                     (vid_d2.hcount <  vga_pkg::RECT_X + vga_pkg::RECT_W) &&
                     (vid_d2.vcount >= vga_pkg::RECT_Y) &&
                     (vid_d2.vcount <  vga_pkg::RECT_Y + vga_pkg::RECT_H);

    assign pixel_on = char_pixels[3'd7 - hrel_d2[2:0]];  // Leftmost pixel is bit 7

    always_comb begin
        if (!in_rect) begin
            rgb_nxt = vid_d2.rgb;
        end else if (pixel_on) begin
            rgb_nxt = fg_color;
        end else begin
            rgb_nxt = vga_pkg::TEXT_BG_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.vcount <= vid_d2.vcount;
            out.vsync  <= vid_d2.vsync;
            out.vblnk  <= vid_d2.vblnk;
            out.hcount <= vid_d2.hcount;
            out.hsync  <= vid_d2.hsync;
            out.hblnk  <= vid_d2.hblnk;
            out.rgb    <= rgb_nxt;
        end
    end

    // Blanking black comes from draw_bg and must survive the overlay
    blank_is_black: assert property (
        @(posedge clk) disable iff (rst)
        (out.hblnk || out.vblnk) |-> (out.rgb == 12'h0_0_0)
    ) else $error("rgb not black during blanking");

endmodule

// ==== vga_top.sv ====
`timescale 1ns/1ns

module vga_top (
    input  logic          clk,
    input  logic          rst,
    input  logic [11:0]   fg_color,
    output vga_pkg::vga_t vga_out
);

    vga_pkg::vga_t       timing_out;
    vga_pkg::vga_t       bg_out;
    vga_pkg::char_addr_t char_xy;
    logic [7:0]          char_code;
    logic [11:0]         font_addr;
    logic [7:0]          char_pixels;

    vga_timing vga_timing_inst (
        .clk (clk),
        .rst (rst),
        .out (timing_out)
    );

    draw_bg draw_bg_inst (
        .clk (clk),
        .rst (rst),
        .in  (timing_out),
        .out (bg_out)
    );

    draw_rect_char draw_rect_char_inst (
        .clk         (clk),
        .rst         (rst),
        .in          (bg_out),
        .out         (vga_out),
        .fg_color    (fg_color),
        .char_pixels (char_pixels),
        .char_xy     (char_xy),
        .font_addr   (font_addr),
        .char_code   (char_code)
    );

    text_buffer text_buffer_inst (
        .clk       (clk),
        .char_xy   (char_xy),
        .char_code (char_code)
    );

    font_rom font_rom_inst (
        .clk         (clk),
        .font_addr   (font_addr),
        .char_pixels (char_pixels)
    );

endmodule

// ==== vga_tb.sv ====
`timescale 1ns/1ns

module vga_tb;

    // 2.2 frames of pixel clocks
    localparam int TIMEOUT_CYCLES =
        int'(vga_pkg::H_TOTAL) * int'(vga_pkg::V_TOTAL) * 22 / 10;
    localparam logic [11:0] FG_YELLOW = 12'hF_F_0;
    localparam logic [11:0] FG_CYAN   = 12'h0_F_F;
    localparam int          ROW5_TOP  = int'(vga_pkg::RECT_Y) + 5 * 16;  // Text row 5, all spaces
    localparam int          RECT_L    = int'(vga_pkg::RECT_X);
    localparam int          RECT_T    = int'(vga_pkg::RECT_Y);

    typedef struct packed {
        logic [1:0]  frame;
        logic [11:0] fg;
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic [11:0] rgb;
    } probe_t;

    logic          clk;
    logic          rst;
    logic [11:0]   fg_color;
    vga_pkg::vga_t vga_out;
    logic [3:0]    sync_exp;

    probe_t probes[$];
    string  probe_names[$];
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;
    int     frame_count = 0;

    vga_top vga_top_inst (
        .clk      (clk),
        .rst      (rst),
        .fg_color (fg_color),
        .vga_out  (vga_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [46:0] expected,
                         input logic [46:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h at hcount %0d, vcount %0d",
                     name, expected, actual, vga_out.hcount, vga_out.vcount);
        end
    endtask

    task automatic add_probe(input string name, input int frame, input logic [11:0] fg,
                             input int h, input int v, input logic [11:0] rgb);
        probe_t p;
        p.frame  = frame[1:0];
        p.fg     = fg;
        p.hcount = h[10:0];
        p.vcount = v[10:0];
        p.rgb    = rgb;
        probes.push_back(p);
        probe_names.push_back(name);
    endtask

    // Rows in raster order within each frame
    task automatic build_probe_table();
        add_probe("bg_top_left",    0, FG_YELLOW, 10, 10, vga_pkg::BG_COLOR);
        add_probe("hblank_line10",  0, FG_YELLOW, 900, 10, 12'h0_0_0);
        add_probe("left_of_rect",   0, FG_YELLOW, RECT_L - 1, RECT_T, vga_pkg::BG_COLOR);
        add_probe("h_line0_col1",   0, FG_YELLOW, RECT_L + 1, RECT_T, vga_pkg::TEXT_BG_COLOR);
        add_probe("right_of_rect",  0, FG_YELLOW, RECT_L + 128, RECT_T, vga_pkg::BG_COLOR);
        add_probe("h_line2_col0",   0, FG_YELLOW, RECT_L, RECT_T + 2, vga_pkg::TEXT_BG_COLOR);
        add_probe("h_line2_col1",   0, FG_YELLOW, RECT_L + 1, RECT_T + 2, FG_YELLOW);
        add_probe("h_line2_col6",   0, FG_YELLOW, RECT_L + 6, RECT_T + 2, FG_YELLOW);
        add_probe("h_line2_col7",   0, FG_YELLOW, RECT_L + 7, RECT_T + 2, vga_pkg::TEXT_BG_COLOR);
        add_probe("e_line2_col1",   0, FG_YELLOW, RECT_L + 9, RECT_T + 2, FG_YELLOW);
        add_probe("h_line3_col3",   0, FG_YELLOW, RECT_L + 3, RECT_T + 3, vga_pkg::TEXT_BG_COLOR);
        add_probe("h_line7_col1",   0, FG_YELLOW, RECT_L + 1, RECT_T + 7, FG_YELLOW);
        add_probe("h_line7_col3",   0, FG_YELLOW, RECT_L + 3, RECT_T + 7, FG_YELLOW);
        add_probe("h_line7_col6",   0, FG_YELLOW, RECT_L + 6, RECT_T + 7, FG_YELLOW);
        add_probe("h_line7_col7",   0, FG_YELLOW, RECT_L + 7, RECT_T + 7, vga_pkg::TEXT_BG_COLOR);
        add_probe("h_line13_col6",  0, FG_YELLOW, RECT_L + 6, RECT_T + 13, FG_YELLOW);
        add_probe("h_line14_col1",  0, FG_YELLOW, RECT_L + 1, RECT_T + 14, vga_pkg::TEXT_BG_COLOR);
        add_probe("row5_space_a",   0, FG_YELLOW, RECT_L + 1, ROW5_TOP, vga_pkg::TEXT_BG_COLOR);
        add_probe("row5_space_b",   0, FG_YELLOW, RECT_L + 6, ROW5_TOP + 7, vga_pkg::TEXT_BG_COLOR);
        add_probe("below_rect",     0, FG_YELLOW, RECT_L + 1, RECT_T + 256, vga_pkg::BG_COLOR);
        add_probe("vblank_line610", 0, FG_YELLOW, 10, 610, 12'h0_0_0);
        // Next frame, new foreground on the same glyph
        add_probe("h_recolor_line2", 1, FG_CYAN, RECT_L + 1, RECT_T + 2, FG_CYAN);
        add_probe("h_recolor_line7", 1, FG_CYAN, RECT_L + 4, RECT_T + 7, FG_CYAN);
        add_probe("row5_space_c",    1, FG_CYAN, RECT_L + 10, ROW5_TOP + 5,
                  vga_pkg::TEXT_BG_COLOR);
        add_probe("bg_mid_screen",   1, FG_CYAN, 600, 300, vga_pkg::BG_COLOR);
    endtask

    task automatic wait_for_pixel(input int frame, input logic [10:0] h, input logic [10:0] v);
        do begin
            @(negedge clk);
        end while (!(frame_count == frame && vga_out.hcount == h && vga_out.vcount == v));
    endtask

    assign sync_exp = {
        (vga_out.hcount >= vga_pkg::H_SYNC_START) && (vga_out.hcount < vga_pkg::H_SYNC_STOP),
        (vga_out.vcount >= vga_pkg::V_SYNC_START) && (vga_out.vcount < vga_pkg::V_SYNC_STOP),
        (vga_out.hcount >= vga_pkg::H_VISIBLE),
        (vga_out.vcount >= vga_pkg::V_VISIBLE)
    };

    // Every pixel of the stream, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            check("sync_blank", sync_exp,
                  {vga_out.hsync, vga_out.vsync, vga_out.hblnk, vga_out.vblnk});
            if (vga_out.hblnk || vga_out.vblnk) begin
                check("blank_black", 12'h0_0_0, vga_out.rgb);
            end
            if (vga_out.vcount >= ROW5_TOP && vga_out.vcount < ROW5_TOP + 16 &&
                vga_out.hcount >= RECT_L && vga_out.hcount < RECT_L + 128) begin
                check("row5_space", vga_pkg::TEXT_BG_COLOR, vga_out.rgb);
            end
            if (vga_out.hcount == vga_pkg::H_TOTAL - 11'd1 &&
                vga_out.vcount == vga_pkg::V_TOTAL - 11'd1) begin
                frame_count <= frame_count + 1;  // Last pixel of a frame
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the probes were not all seen within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int     prev_h;
        int     prev_v;
        int     next_h;
        int     next_v;
        probe_t p;

        rst      = 1'b1;
        fg_color = 12'h0_0_0;
        build_probe_table();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // Overlay registers flush their reset zeros first
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            @(negedge clk);
            check("startup_sync_blank", 4'b0000,
                  {vga_out.hsync, vga_out.vsync, vga_out.hblnk, vga_out.vblnk});
            if (i < 3) begin
                check("startup_rgb", 12'h0_0_0, vga_out.rgb);
            end
        end

        do begin
            @(negedge clk);
        end while (vga_out.hcount != 11'd1);
        prev_h = 1;
        prev_v = 0;
        repeat (int'(vga_pkg::H_TOTAL) + 16) begin
            @(negedge clk);
            next_h = (prev_h == int'(vga_pkg::H_TOTAL) - 1) ? 0 : prev_h + 1;
            next_v = (prev_h == int'(vga_pkg::H_TOTAL) - 1) ? prev_v + 1 : prev_v;
            check("hcount_step", {next_v[10:0], next_h[10:0]},
                  {vga_out.vcount, vga_out.hcount});
            prev_h = vga_out.hcount;
            prev_v = vga_out.vcount;
        end

        foreach (probes[i]) begin
            p = probes[i];
            @(posedge clk);
            #1 fg_color = p.fg;
            wait_for_pixel(p.frame, p.hcount, p.vcount);
            check(probe_names[i], p.rgb, vga_out.rgb);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
vga_pkg.sv
vga_timing.sv
draw_bg.sv
text_buffer.sv
font_rom.sv
draw_rect_char.sv
vga_top.sv
vga_tb.sv
